//--- soc_map_pkg.sv
package soc_map_pkg;

    // number of slave slots behind the router
    localparam int slave_n = 4;

    // address bits that pick the slot
    localparam int slot_lsb = 16;
    localparam int slot_msb = 17;
    localparam int slot_w   = slot_msb - slot_lsb + 1;

    // slot numbers
    // slot 3 is a hole in the map, reads zero and drops writes
    localparam logic [slot_w-1:0] slot_ram  = 2'd0;
    localparam logic [slot_w-1:0] slot_gpio = 2'd1;
    localparam logic [slot_w-1:0] slot_pwm  = 2'd2;
    localparam logic [slot_w-1:0] slot_none = 2'd3;

endpackage : soc_map_pkg

//--- soc_periph_pkg.sv
package soc_periph_pkg;

    // bus word width
    localparam int data_w = 32;

    // gpio pin count
    localparam int gpio_w = 8;

    // data ram geometry, word index taken from addr[7:2]
    localparam int ram_depth   = 64;
    localparam int ram_aw      = $clog2(ram_depth);
    localparam int ram_idx_lsb = 2;
    localparam int ram_idx_msb = ram_idx_lsb + ram_aw - 1;

    // register offsets are decoded from the low address bits
    localparam int reg_off_w = 4;

    // gpio register offsets
    localparam logic [reg_off_w-1:0] reg_gpi_off = 4'h0;
    localparam logic [reg_off_w-1:0] reg_gpo_off = 4'h4;
    localparam logic [reg_off_w-1:0] reg_gpd_off = 4'h8;

    // pwm register offsets
    localparam logic [reg_off_w-1:0] reg_period_off = 4'h0;
    localparam logic [reg_off_w-1:0] reg_duty_off   = 4'h4;

    // pwm counter width, also the width of period and duty
    localparam int pwm_cnt_w = 16;

endpackage : soc_periph_pkg

//--- bus_router.sv
module bus_router
    import soc_map_pkg::*, soc_periph_pkg::*;
(
    input  logic                             clk,
    input  logic                             arst_n,
    // master side
    input  logic [31:0]                      addr,
    input  logic                             we,
    input  logic [data_w-1:0]                wd,
    output logic [data_w-1:0]                rd,
    // slave side
    output logic [31:0]                      addr_s,
    output logic [slave_n-1:0]               we_s,
    output logic [data_w-1:0]                wd_s,
    input  logic [slave_n-1:0][data_w-1:0]   rd_s
);

    logic [slot_w-1:0] slot;

    assign slot = addr[slot_msb:slot_lsb];

    // address and write data fan out to every slave
    assign addr_s = addr;
    assign wd_s   = wd;

    // write strobe goes only to the decoded slot
    always_comb begin
        we_s = '0;
        if (we && (slot != slot_none)) begin
            we_s[slot] = 1'b1;
        end
    end

    // read mux, the unmapped slot answers zero
    always_comb begin
        if (slot == slot_none) begin
            rd = '0;
        end else begin
            rd = rd_s[slot];
        end
    end

    // at most one slave sees a write in any cycle
    we_s_onehot_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(we_s)
    ) else $error("bus_router: more than one slave write strobe active");

endmodule : bus_router

//--- data_ram.sv
module data_ram
    import soc_periph_pkg::*;
(
    input  logic              clk,
    input  logic [31:0]       addr,
    input  logic              we,
    input  logic [data_w-1:0] wd,
    output logic [data_w-1:0] rd
);

    logic [data_w-1:0] mem [ram_depth];
    logic [ram_aw-1:0] idx;

    // word index, byte offset bits are ignored
    assign idx = addr[ram_idx_msb:ram_idx_lsb];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[idx] <= wd;
        end
    end

    // asynchronous read port
    assign rd = mem[idx];

    // a write with an unknown address would corrupt an unknown word
    addr_known_a : assert property (
        @(posedge clk)
        we |-> !$isunknown(addr)
    ) else $error("data_ram: write with unknown address");

endmodule : data_ram

//--- gpio_port.sv
module gpio_port
    import soc_periph_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // router side
    input  logic [31:0]       addr,
    input  logic              we,
    input  logic [data_w-1:0] wd,
    output logic [data_w-1:0] rd,
    // pin side
    input  logic [gpio_w-1:0] gpi,
    output logic [gpio_w-1:0] gpo,
    output logic [gpio_w-1:0] gpd
);

    logic [reg_off_w-1:0] off;
    logic [gpio_w-1:0]    gpi_meta;
    logic [gpio_w-1:0]    gpi_sync;
    logic                 gpo_we;
    logic                 gpd_we;

    assign off = addr[reg_off_w-1:0];

    // gpi offset is read only, so no strobe is decoded for it
    assign gpo_we = we && (off == reg_gpo_off);
    assign gpd_we = we && (off == reg_gpd_off);

    // two flop synchronizer on the input pins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpi_meta <= '0;
            gpi_sync <= '0;
        end else begin
            gpi_meta <= gpi;
            gpi_sync <= gpi_meta;
        end
    end

    // output value and direction registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpo <= '0;
            gpd <= '0;
        end else begin
            if (gpo_we) begin
                gpo <= wd[gpio_w-1:0];
            end
            if (gpd_we) begin
                gpd <= wd[gpio_w-1:0];
            end
        end
    end

    // read-back, zero extended to the bus word
    always_comb begin
        case (off)
            reg_gpi_off: rd = data_w'(gpi_sync);
            reg_gpo_off: rd = data_w'(gpo);
            reg_gpd_off: rd = data_w'(gpd);
            default:     rd = '0;
        endcase
    end

endmodule : gpio_port

//--- pwm_timer.sv
module pwm_timer
    import soc_periph_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [pwm_cnt_w-1:0] period,
    output logic [pwm_cnt_w-1:0] count
);

    logic wrap;

    // at-or-above compare so a lowered period takes effect at once
    assign wrap = (count >= period);

    // free running up counter, one period is period + 1 cycles
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (wrap) begin
            count <= '0;
        end else begin
            count <= count + pwm_cnt_w'(1);
        end
    end

    // counter never runs past the programmed period
    wrap_to_zero_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        (count >= period) |=> (count == '0)
    ) else $error("pwm_timer: count did not wrap at period");

endmodule : pwm_timer

//--- pwm_unit.sv
module pwm_unit
    import soc_periph_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // router side
    input  logic [31:0]       addr,
    input  logic              we,
    input  logic [data_w-1:0] wd,
    output logic [data_w-1:0] rd,
    // pin side
    output logic              pwm
);

    logic [reg_off_w-1:0] off;
    logic [pwm_cnt_w-1:0] period;
    logic [pwm_cnt_w-1:0] duty;
    logic [pwm_cnt_w-1:0] count;

    assign off = addr[reg_off_w-1:0];

    // period and duty registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            period <= '0;
            duty   <= '0;
        end else if (we) begin
            if (off == reg_period_off) begin
                period <= wd[pwm_cnt_w-1:0];
            end
            if (off == reg_duty_off) begin
                duty <= wd[pwm_cnt_w-1:0];
            end
        end
    end

    always_comb begin
        case (off)
            reg_period_off: rd = data_w'(period);
            reg_duty_off:   rd = data_w'(duty);
            default:        rd = '0;
        endcase
    end

    pwm_timer pwm_timer_0 (
        .clk    (clk),
        .arst_n (arst_n),
        .period (period),
        .count  (count)
    );

    // high while count is below duty
    // duty 0 gives a flat low, duty above period a flat high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pwm <= 1'b0;
        end else begin
            pwm <= (count < duty);
        end
    end

endmodule : pwm_unit

//--- soc_top.sv
module soc_top
    import soc_map_pkg::*, soc_periph_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    // bus master side
    input  logic [31:0]       addr,
    input  logic              we,
    input  logic [data_w-1:0] wd,
    output logic [data_w-1:0] rd,
    // gpio pins
    input  logic [gpio_w-1:0] gpi,
    output logic [gpio_w-1:0] gpo,
    output logic [gpio_w-1:0] gpd,
    // pwm pin
    output logic              pwm
);

    logic [31:0]                    addr_s;
    logic [slave_n-1:0]             we_s;
    logic [data_w-1:0]              wd_s;
    logic [slave_n-1:0][data_w-1:0] rd_s;

    // nothing lives in the unmapped slot
    assign rd_s[slot_none] = '0;

    bus_router bus_router_0 (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr),
        .we     (we),
        .wd     (wd),
        .rd     (rd),
        .addr_s (addr_s),
        .we_s   (we_s),
        .wd_s   (wd_s),
        .rd_s   (rd_s)
    );

    data_ram data_ram_0 (
        .clk  (clk),
        .addr (addr_s),
        .we   (we_s[slot_ram]),
        .wd   (wd_s),
        .rd   (rd_s[slot_ram])
    );

    gpio_port gpio_port_0 (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr_s),
        .we     (we_s[slot_gpio]),
        .wd     (wd_s),
        .rd     (rd_s[slot_gpio]),
        .gpi    (gpi),
        .gpo    (gpo),
        .gpd    (gpd)
    );

    pwm_unit pwm_unit_0 (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr_s),
        .we     (we_s[slot_pwm]),
        .wd     (wd_s),
        .rd     (rd_s[slot_pwm]),
        .pwm    (pwm)
    );

endmodule : soc_top

//--- tb_soc_top.sv
module tb_soc_top
    import soc_map_pkg::*, soc_periph_pkg::*;
();

    localparam int ram_n       = 24;
    localparam int pwm_n       = 6;
    localparam int pwm_pmax    = 33;
    localparam int cycle_limit = 16 + 4 * ram_n + 64 + pwm_n * (3 * (pwm_pmax + 1) + 4) + 100;

    logic              clk;
    logic              arst_n;
    logic [31:0]       addr;
    logic              we;
    logic [data_w-1:0] wd;
    logic [data_w-1:0] rd;
    logic [gpio_w-1:0] gpi;
    logic [gpio_w-1:0] gpo;
    logic [gpio_w-1:0] gpd;
    logic              pwm;

    // reference model state
    logic [data_w-1:0]    ram_m [ram_depth];
    logic [ram_depth-1:0] ram_ok;
    logic [gpio_w-1:0]    gpi_m;
    logic                 gpi_ok;
    logic [gpio_w-1:0]    gpo_m;
    logic [gpio_w-1:0]    gpd_m;
    logic [pwm_cnt_w-1:0] period_m;
    logic [pwm_cnt_w-1:0] duty_m;
    logic [pwm_cnt_w-1:0] duty_prev;
    logic [data_w-1:0]    exp_rd;
    logic                 exp_ok;
    logic [31:0]          ram_addr [ram_n];

    int err_cnt  = 0;
    int test_cnt = 0;
    int fail_cnt = 0;
    int cyc      = 0;
    int seed;

    soc_top dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .addr   (addr),
        .we     (we),
        .wd     (wd),
        .rd     (rd),
        .gpi    (gpi),
        .gpo    (gpo),
        .gpd    (gpd),
        .pwm    (pwm)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // model follows the write rules of the bus
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ram_ok    <= '0;
            gpo_m     <= '0;
            gpd_m     <= '0;
            period_m  <= '0;
            duty_m    <= '0;
            duty_prev <= '0;
        end else begin
            duty_prev <= duty_m;
            if (we) begin
                case (addr[slot_msb:slot_lsb])
                    slot_ram: begin
                        ram_m[addr[ram_idx_msb:ram_idx_lsb]]  <= wd;
                        ram_ok[addr[ram_idx_msb:ram_idx_lsb]] <= 1'b1;
                    end
                    slot_gpio: begin
                        if (addr[reg_off_w-1:0] == reg_gpo_off) begin
                            gpo_m <= wd[gpio_w-1:0];
                        end
                        if (addr[reg_off_w-1:0] == reg_gpd_off) begin
                            gpd_m <= wd[gpio_w-1:0];
                        end
                    end
                    slot_pwm: begin
                        if (addr[reg_off_w-1:0] == reg_period_off) begin
                            period_m <= wd[pwm_cnt_w-1:0];
                        end
                        if (addr[reg_off_w-1:0] == reg_duty_off) begin
                            duty_m <= wd[pwm_cnt_w-1:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // expected read word, exp_ok low where the value is not yet defined
    always_comb begin
        exp_rd = '0;
        exp_ok = 1'b1;
        case (addr[slot_msb:slot_lsb])
            slot_ram: begin
                exp_rd = ram_m[addr[ram_idx_msb:ram_idx_lsb]];
                exp_ok = ram_ok[addr[ram_idx_msb:ram_idx_lsb]];
            end
            slot_gpio: begin
                if (addr[reg_off_w-1:0] == reg_gpi_off) begin
                    exp_rd = data_w'(gpi_m);
                    exp_ok = gpi_ok;
                end else if (addr[reg_off_w-1:0] == reg_gpo_off) begin
                    exp_rd = data_w'(gpo_m);
                end else if (addr[reg_off_w-1:0] == reg_gpd_off) begin
                    exp_rd = data_w'(gpd_m);
                end
            end
            slot_pwm: begin
                if (addr[reg_off_w-1:0] == reg_period_off) begin
                    exp_rd = data_w'(period_m);
                end else if (addr[reg_off_w-1:0] == reg_duty_off) begin
                    exp_rd = data_w'(duty_m);
                end
            end
            default: begin
            end
        endcase
    end

    rd_check_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        exp_ok |-> (rd == exp_rd)
    ) else begin
        err_cnt++;
        $display("[ERROR] %0t: rd 0x%08h, expected 0x%08h at addr 0x%08h",
                 $time, $sampled(rd), $sampled(exp_rd), $sampled(addr));
    end

    gpo_check_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        gpo == gpo_m
    ) else begin
        err_cnt++;
        $display("[ERROR] %0t: gpo 0x%02h, expected 0x%02h",
                 $time, $sampled(gpo), $sampled(gpo_m));
    end

    gpd_check_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        gpd == gpd_m
    ) else begin
        err_cnt++;
        $display("[ERROR] %0t: gpd 0x%02h, expected 0x%02h",
                 $time, $sampled(gpd), $sampled(gpd_m));
    end

    // duty zero in the previous cycle forces a low output now
    pwm_low_a : assert property (
        @(posedge clk) disable iff (!arst_n)
        (duty_prev == '0) |-> !pwm
    ) else begin
        err_cnt++;
        $display("[ERROR] %0t: pwm high while duty is zero", $time);
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cycle_limit) begin
            $display("run timed out after %0d cycles, tests did not finish", cyc);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic logic [31:0] slot_addr(input logic [slot_w-1:0] s, input logic [15:0] off);
        return {14'd0, s, off};
    endfunction

    task automatic bus_write(input logic [31:0] a, input logic [data_w-1:0] d);
        addr = a;
        wd   = d;
        we   = 1'b1;
        @(posedge clk);
        #1;
        we   = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] a);
        addr = a;
        we   = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int err_start);
        test_cnt++;
        if (err_cnt == err_start) begin
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: %0d errors", name, err_cnt - err_start);
        end
    endtask

    task automatic reset_values();
        int e;
        e = err_cnt;
        assert (gpo == '0 && gpd == '0 && pwm == 1'b0) else begin
            err_cnt++;
            $display("[ERROR] %0t: pins not zero after reset", $time);
        end
        bus_read(slot_addr(slot_pwm, 16'(reg_period_off)));
        bus_read(slot_addr(slot_pwm, 16'(reg_duty_off)));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpo_off)));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpd_off)));
        report_test("reset", e);
    endtask

    task automatic ram_readback();
        int          e;
        logic [31:0] r;
        logic [5:0]  idx;
        e = err_cnt;
        for (int i = 0; i < ram_n; i++) begin
            r           = $random(seed);
            idx         = r[5:0];
            ram_addr[i] = slot_addr(slot_ram, 16'({idx, 2'b00}));
            bus_write(ram_addr[i], $random(seed));
            bus_read(ram_addr[i]);
        end
        // read back after all writes, duplicates hold the last word
        for (int i = 0; i < ram_n; i++) begin
            bus_read(ram_addr[i]);
        end
        report_test("ram", e);
    endtask

    task automatic gpio_access();
        int          e;
        logic [31:0] r;
        e = err_cnt;
        bus_write(slot_addr(slot_gpio, 16'(reg_gpo_off)), $random(seed));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpo_off)));
        bus_write(slot_addr(slot_gpio, 16'(reg_gpd_off)), $random(seed));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpd_off)));
        // new input level needs the synchronizer delay
        r      = $random(seed);
        gpi_ok = 1'b0;
        gpi    = r[gpio_w-1:0];
        idle(3);
        gpi_m  = gpi;
        gpi_ok = 1'b1;
        bus_read(slot_addr(slot_gpio, 16'(reg_gpi_off)));
        // input register is read only
        bus_write(slot_addr(slot_gpio, 16'(reg_gpi_off)), $random(seed));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpi_off)));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpo_off)));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpd_off)));
        report_test("gpio", e);
    endtask

    task automatic unmapped_slot();
        int e;
        e = err_cnt;
        bus_read(slot_addr(slot_none, 16'h0000));
        bus_read(slot_addr(slot_none, 16'h0004));
        bus_read(slot_addr(slot_none, 16'h0008));
        // offsets that alias the registers of the mapped slaves
        bus_write(slot_addr(slot_none, 16'(reg_gpo_off)), $random(seed));
        bus_write(slot_addr(slot_none, 16'(reg_gpd_off)), $random(seed));
        bus_write(slot_addr(slot_none, 16'(reg_period_off)), $random(seed));
        bus_write(slot_addr(slot_none, 16'(reg_duty_off)), $random(seed));
        for (int i = 0; i < 4; i++) begin
            bus_write({14'd0, slot_none, ram_addr[i][15:0]}, $random(seed));
        end
        bus_read(slot_addr(slot_none, 16'h0000));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpo_off)));
        bus_read(slot_addr(slot_gpio, 16'(reg_gpd_off)));
        bus_read(slot_addr(slot_pwm, 16'(reg_period_off)));
        bus_read(slot_addr(slot_pwm, 16'(reg_duty_off)));
        for (int i = 0; i < ram_n; i++) begin
            bus_read(ram_addr[i]);
        end
        report_test("unmapped", e);
    endtask

    task automatic pwm_case(input int p, input int d);
        int high;
        int expect_high;
        high = 0;
        bus_write(slot_addr(slot_pwm, 16'(reg_period_off)), 32'(p));
        bus_write(slot_addr(slot_pwm, 16'(reg_duty_off)), 32'(d));
        idle(2 * (p + 1) + 2);
        for (int i = 0; i <= p; i++) begin
            if (pwm) begin
                high++;
            end
            @(posedge clk);
            #1;
        end
        expect_high = (d < p + 1) ? d : p + 1;
        assert (high == expect_high) else begin
            err_cnt++;
            $display("[ERROR] %0t: period %0d duty %0d gave %0d high cycles, expected %0d",
                     $time, p, d, high, expect_high);
        end
    endtask

    task automatic pwm_duty_sweep();
        int          e;
        logic [31:0] r;
        e = err_cnt;
        pwm_case(9, 3);
        pwm_case(9, 0);
        pwm_case(4, 7);
        pwm_case(15, 15);
        pwm_case(7, 8);
        r = $random(seed);
        pwm_case(int'(r[4:0]) + 2, int'(r[9:5]));
        report_test("pwm", e);
    endtask

    initial begin
        seed   = 32'hadb1;
        arst_n = 1'b0;
        addr   = '0;
        we     = 1'b0;
        wd     = '0;
        gpi    = '0;
        gpi_m  = '0;
        gpi_ok = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        reset_values();
        ram_readback();
        gpio_access();
        unmapped_slot();
        pwm_duty_sweep();
        $display("tests: %0d run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : tb_soc_top

//--- compile.f
soc_map_pkg.sv
soc_periph_pkg.sv
bus_router.sv
data_ram.sv
gpio_port.sv
pwm_timer.sv
pwm_unit.sv
soc_top.sv
tb_soc_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide on the log contents
verilator --binary --assert --top-module tb_soc_top -f compile.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    ; grep -q "^Done: no errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
